// File: exe_stage.f
+incdir+source
source/exe_isa_pkg.sv
source/exe_pipe_pkg.sv
source/operand_resolve.sv
source/alu_unit.sv
source/branch_unit.sv
source/exe_mem_reg.sv
source/exe_stage.sv
tb/tb_clock.sv
tb/exe_stage_tb.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_stage_tb
FILELIST  ?= exe_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/exe_stage_tb.sv
`timescale 1ns/10ps

module exe_stage_tb;

import exe_isa_pkg::*;
import exe_pipe_pkg::*;

localparam int clk_period = 20;
localparam stage_ctrl_t ctrl_run       = '{flush: 1'b0, en: 1'b1, bubble: 1'b0};
localparam stage_ctrl_t ctrl_hold      = '{flush: 1'b0, en: 1'b0, bubble: 1'b0};
localparam stage_ctrl_t ctrl_flush     = '{flush: 1'b1, en: 1'b1, bubble: 1'b0};
localparam stage_ctrl_t ctrl_flush_off = '{flush: 1'b1, en: 1'b0, bubble: 1'b0};
localparam stage_ctrl_t ctrl_bubble    = '{flush: 1'b0, en: 1'b1, bubble: 1'b1};
localparam fwd_t no_fwd = '{sel_a: FWD_NONE, sel_b: FWD_NONE, mem_val: 32'h0, wbk_val: 32'h0};

// one table entry, stimulus then expected outputs
typedef struct packed {
    exe_in_t     exe;
    fwd_t        fwd;
    stage_ctrl_t ctrl;
    exe_mem_t    exp_mem;
    redirect_t   exp_redir;
} row_t;

logic        clk;
logic        rst;
exe_in_t     exe_i;
fwd_t        fwd_i;
stage_ctrl_t ctrl_i;
exe_mem_t    mem_o;
redirect_t   redirect_o;

row_t      rows[$];
exe_mem_t  last_mem;
redirect_t last_redir;
int        n_rows;
int        errors;
int        seed;

tb_clock i_tb_clock (.clk_o(clk));

exe_stage i_exe_stage (
    .clk        (clk),
    .rst        (rst),
    .exe_i      (exe_i),
    .fwd_i      (fwd_i),
    .ctrl_i     (ctrl_i),
    .mem_o      (mem_o),
    .redirect_o (redirect_o)
);

// ----------------------------------------
// reference rules

function automatic arch_t alu_ref(alu_op_t op, arch_t a, arch_t b);
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_SLL:  return a << b[4:0];
        ALU_SLT:  return arch_t'($signed(a) < $signed(b));
        ALU_SLTU: return arch_t'(a < b);
        ALU_XOR:  return a ^ b;
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return arch_t'($signed(a) >>> b[4:0]);
        ALU_OR:   return a | b;
        ALU_AND:  return a & b;
        default:  return b;
    endcase
endfunction

function automatic logic branch_ref(branch_sel_t sel, logic uns, arch_t a, arch_t b);
    logic lt;
    lt = uns ? (a < b) : ($signed(a) < $signed(b));
    case (sel)
        BR_BEQ:  return a == b;
        BR_BNE:  return a != b;
        BR_BLT:  return lt;
        default: return !lt;
    endcase
endfunction

// plain register-writing instruction
function automatic exe_in_t make_exe(arch_t pc, arch_t a, arch_t b, alu_op_t op, ewb_sel_t ewb);
    exe_in_t e;
    e = '0;
    e.valid = 1'b1;
    e.pc = pc;
    e.op_a = a;
    e.op_b = b;
    e.alu_op = op;
    e.ewb_sel = ewb;
    e.rd_we = 1'b1;
    e.rd_addr = rf_addr_t'(pc[6:2]);
    return e;
endfunction

function automatic exe_in_t make_branch(arch_t pc, arch_t a, arch_t b, branch_sel_t sel,
                                        logic uns);
    exe_in_t e;
    e = make_exe(pc, a, b, ALU_ADD, EWB_ALU);
    e.is_branch = 1'b1;
    e.br_sel = sel;
    e.bc_uns = uns;
    e.rd_we = 1'b0;
    e.rd_addr = '0;
    e.branch_target = pc + 32'h400;
    return e;
endfunction

// control priority decides what the register shows one cycle later
task automatic push(input exe_in_t e, input fwd_t f, input stage_ctrl_t c, input arch_t res,
                    input logic tk, input arch_t tgt);
    row_t r;
    r.exe = e;
    r.fwd = f;
    r.ctrl = c;
    if (c.flush || (c.en && c.bubble)) begin
        r.exp_mem = '0;
        r.exp_redir = '0;
    end else if (!c.en) begin
        r.exp_mem = last_mem;
        r.exp_redir = last_redir;
    end else begin
        r.exp_mem = '{valid: e.valid, pc: e.pc, result: res, rd_we: e.rd_we, rd_addr: e.rd_addr};
        r.exp_redir = '{taken: tk, target: tgt};
    end
    last_mem = r.exp_mem;
    last_redir = r.exp_redir;
    rows.push_back(r);
endtask

// ----------------------------------------
// stimulus table

task automatic build_table();
    exe_in_t e;
    fwd_t    f;
    arch_t   a;
    arch_t   b;
    arch_t   ra;
    arch_t   rb;
    logic    tk;
    push(make_exe(32'h100, 32'h10, 32'h20, ALU_ADD, EWB_ALU), no_fwd, ctrl_run, 32'h30, 0, 0);
    push(make_exe(32'h104, 32'h5, 32'h7, ALU_SUB, EWB_ALU), no_fwd, ctrl_run, 32'hfffffffe, 0, 0);
    push(make_exe(32'h108, 32'h1, 32'h21, ALU_SLL, EWB_ALU), no_fwd, ctrl_run, 32'h2, 0, 0);
    // -1 against 1, signed and unsigned order differ
    push(make_exe(32'h10c, 32'hffffffff, 32'h1, ALU_SLT, EWB_ALU), no_fwd, ctrl_run, 32'h1, 0, 0);
    push(make_exe(32'h110, 32'hffffffff, 32'h1, ALU_SLTU, EWB_ALU), no_fwd, ctrl_run, 32'h0, 0, 0);
    push(make_exe(32'h114, 32'hff00ff00, 32'h0ff00ff0, ALU_XOR, EWB_ALU), no_fwd, ctrl_run,
         32'hf0f0f0f0, 0, 0);
    push(make_exe(32'h118, 32'h80000000, 32'h4, ALU_SRL, EWB_ALU), no_fwd, ctrl_run,
         32'h08000000, 0, 0);
    push(make_exe(32'h11c, 32'h80000000, 32'h4, ALU_SRA, EWB_ALU), no_fwd, ctrl_run,
         32'hf8000000, 0, 0);
    push(make_exe(32'h120, 32'hf0, 32'h0f, ALU_OR, EWB_ALU), no_fwd, ctrl_run, 32'hff, 0, 0);
    push(make_exe(32'h124, 32'hf0f0, 32'hff00, ALU_AND, EWB_ALU), no_fwd, ctrl_run, 32'hf000, 0, 0);
    push(make_exe(32'h128, 32'h9, 32'h12345000, ALU_PASS_B, EWB_ALU), no_fwd, ctrl_run,
         32'h12345000, 0, 0);
    // writeback selects
    push(make_exe(32'h140, 32'h1, 32'habcde000, ALU_ADD, EWB_IMM_U), no_fwd, ctrl_run,
         32'habcde000, 0, 0);
    push(make_exe(32'h144, 32'h1, 32'h2, ALU_ADD, EWB_PC_INC4), no_fwd, ctrl_run, 32'h148, 0, 0);
    for (int k = 0; k < 22; k++) begin
        a = $random(seed);
        b = $random(seed);
        e = make_exe(32'h200 + 4 * k, a, b, alu_op_t'(4'(k % 11)), EWB_ALU);
        push(e, no_fwd, ctrl_run, alu_ref(e.alu_op, a, b), 0, 0);
    end
    // every select pair, sub shows which side came from where
    for (int k = 0; k < 9; k++) begin
        a = $random(seed);
        b = $random(seed);
        f = '{sel_a: fwd_sel_t'(2'(k % 3)), sel_b: fwd_sel_t'(2'(k / 3)),
              mem_val: $random(seed), wbk_val: $random(seed)};
        ra = (f.sel_a == FWD_MEM) ? f.mem_val : (f.sel_a == FWD_WBK) ? f.wbk_val : a;
        rb = (f.sel_b == FWD_MEM) ? f.mem_val : (f.sel_b == FWD_WBK) ? f.wbk_val : b;
        push(make_exe(32'h280 + 4 * k, a, b, ALU_SUB, EWB_ALU), f, ctrl_run, ra - rb, 0, 0);
    end
    push(make_branch(32'h300, 32'h7, 32'h7, BR_BEQ, 1'b0), no_fwd, ctrl_run, 32'he, 1, 32'h700);
    push(make_branch(32'h304, 32'h7, 32'h7, BR_BNE, 1'b0), no_fwd, ctrl_run, 32'he, 0, 0);
    push(make_branch(32'h308, 32'hffffffff, 32'h1, BR_BLT, 1'b0), no_fwd, ctrl_run, 0, 1, 32'h708);
    push(make_branch(32'h30c, 32'hffffffff, 32'h1, BR_BLT, 1'b1), no_fwd, ctrl_run, 0, 0, 0);
    push(make_branch(32'h310, 32'hffffffff, 32'h1, BR_BGE, 1'b0), no_fwd, ctrl_run, 0, 0, 0);
    push(make_branch(32'h314, 32'hffffffff, 32'h1, BR_BGE, 1'b1), no_fwd, ctrl_run, 0, 1, 32'h714);
    push(make_branch(32'h318, 32'h5, 32'h5, BR_BGE, 1'b1), no_fwd, ctrl_run, 32'ha, 1, 32'h718);
    for (int k = 0; k < 16; k++) begin
        a = $random(seed);
        b = k[3] ? a : $random(seed);
        e = make_branch(32'h340 + 4 * k, a, b, branch_sel_t'(k[1:0]), k[2]);
        tk = branch_ref(e.br_sel, e.bc_uns, a, b);
        push(e, no_fwd, ctrl_run, a + b, tk, tk ? e.branch_target : 32'h0);
    end
    // jalr, then control rows that hold and clear it
    e = make_exe(32'h400, 32'h1000, 32'h24, ALU_ADD, EWB_PC_INC4);
    e.is_jalr = 1'b1;
    push(e, no_fwd, ctrl_run, 32'h404, 1, 32'h1024);
    e = make_exe(32'h504, 32'h9, 32'h9, ALU_ADD, EWB_ALU);
    push(e, no_fwd, ctrl_hold, 32'h12, 0, 0);
    push(e, no_fwd, ctrl_hold, 32'h12, 0, 0);
    push(e, no_fwd, ctrl_flush, 32'h12, 0, 0);
    push(make_exe(32'h500, 32'h3, 32'h4, ALU_ADD, EWB_ALU), no_fwd, ctrl_run, 32'h7, 0, 0);
    push(e, no_fwd, ctrl_bubble, 32'h12, 0, 0);
    push(make_exe(32'h508, 32'h3, 32'h4, ALU_ADD, EWB_ALU), no_fwd, ctrl_run, 32'h7, 0, 0);
    push(e, no_fwd, ctrl_flush_off, 32'h12, 0, 0);
    push(e, no_fwd, ctrl_run, 32'h12, 0, 0);
    n_rows = rows.size();
endtask

// ----------------------------------------
// checks

task automatic check_word(input string ctx, input string name, input arch_t exp,
                          input arch_t act);
    if (act !== exp) begin
        errors++;
        $display("Fail %s %s expected %h actual %h", ctx, name, exp, act);
    end
endtask

task automatic check_row(input int idx, input row_t r);
    string ctx;
    ctx = $sformatf("row %0d", idx);
    if ($isunknown(mem_o) || $isunknown(redirect_o)) begin
        errors++;
        $display("row %0d has unknown bits on the DUT outputs", idx);
    end
    check_word(ctx, "mem_o.valid", arch_t'(r.exp_mem.valid), arch_t'(mem_o.valid));
    check_word(ctx, "mem_o.pc", r.exp_mem.pc, mem_o.pc);
    check_word(ctx, "mem_o.result", r.exp_mem.result, mem_o.result);
    check_word(ctx, "mem_o.rd_we", arch_t'(r.exp_mem.rd_we), arch_t'(mem_o.rd_we));
    check_word(ctx, "mem_o.rd_addr", arch_t'(r.exp_mem.rd_addr), arch_t'(mem_o.rd_addr));
    check_word(ctx, "redirect_o.taken", arch_t'(r.exp_redir.taken), arch_t'(redirect_o.taken));
    check_word(ctx, "redirect_o.target", r.exp_redir.target, redirect_o.target);
endtask

initial begin
    errors = 0;
    n_rows = 0;
    seed = 32'hd9ac;
    rst = 1'b1;
    exe_i = '0;
    fwd_i = no_fwd;
    ctrl_i = ctrl_run;
    last_mem = '0;
    last_redir = '0;
    build_table();
    // valid jalr held at the input while reset is high
    exe_i = rows[0].exe;
    exe_i.is_jalr = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    check_word("after reset", "mem_o.valid", '0, arch_t'(mem_o.valid));
    check_word("after reset", "mem_o.rd_we", '0, arch_t'(mem_o.rd_we));
    check_word("after reset", "redirect_o.taken", '0, arch_t'(redirect_o.taken));
    // one row per cycle, driven 2 ns after the edge and checked 1 ns after the next
    for (int i = 0; i < n_rows; i++) begin
        exe_i = rows[i].exe;
        fwd_i = rows[i].fwd;
        ctrl_i = rows[i].ctrl;
        @(posedge clk);
        #1;
        check_row(i, rows[i]);
        #1;
    end
    $display("%0d errors in %0d rows", errors, n_rows);
    if (errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

// watchdog, twice the expected run length
initial begin
    wait (n_rows > 0);
    #((n_rows + 20) * clk_period * 2);
    $display("watchdog expired before the table finished");
    $display("tests failed");
    $finish;
end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o
);

// 20 ns period
localparam int half_period = 10;

initial begin
    clk_o = 1'b0;
    forever #half_period clk_o = ~clk_o;
end

endmodule

// File: source/exe_stage.sv
`timescale 1ns/10ps

module exe_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  exe_pipe_pkg::exe_in_t     exe_i,
    input  exe_pipe_pkg::fwd_t        fwd_i,
    input  exe_pipe_pkg::stage_ctrl_t ctrl_i,
    output exe_pipe_pkg::exe_mem_t    mem_o,
    output exe_pipe_pkg::redirect_t   redirect_o
);

import exe_isa_pkg::*;

// resolved operands
arch_t op_a_r;
arch_t op_b_r;

// unit results
arch_t alu_out;
arch_t ewb_out;
logic  br_taken;

operand_resolve i_operand_resolve (
    .clk    (clk),
    .rst    (rst),
    .op_a_i (exe_i.op_a),
    .op_b_i (exe_i.op_b),
    .fwd_i  (fwd_i),
    .op_a_o (op_a_r),
    .op_b_o (op_b_r)
);

// alu and branch compare work side by side on the same operands
alu_unit i_alu_unit (
    .clk       (clk),
    .rst       (rst),
    .op_a_i    (op_a_r),
    .op_b_i    (op_b_r),
    .pc_i      (exe_i.pc),
    .alu_op_i  (exe_i.alu_op),
    .ewb_sel_i (exe_i.ewb_sel),
    .alu_o     (alu_out),
    .ewb_o     (ewb_out)
);

branch_unit i_branch_unit (
    .clk         (clk),
    .rst         (rst),
    .op_a_i      (op_a_r),
    .op_b_i      (op_b_r),
    .br_sel_i    (exe_i.br_sel),
    .bc_uns_i    (exe_i.bc_uns),
    .is_branch_i (exe_i.is_branch),
    .taken_o     (br_taken)
);

exe_mem_reg i_exe_mem_reg (
    .clk        (clk),
    .rst        (rst),
    .ctrl_i     (ctrl_i),
    .exe_i      (exe_i),
    .alu_i      (alu_out),
    .ewb_i      (ewb_out),
    .br_taken_i (br_taken),
    .mem_o      (mem_o),
    .redirect_o (redirect_o)
);

endmodule

// File: source/exe_mem_reg.sv
`timescale 1ns/10ps

module exe_mem_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  exe_pipe_pkg::stage_ctrl_t ctrl_i,
    input  exe_pipe_pkg::exe_in_t     exe_i,
    input  exe_isa_pkg::arch_t        alu_i,
    input  exe_isa_pkg::arch_t        ewb_i,
    input  logic                      br_taken_i,
    output exe_pipe_pkg::exe_mem_t    mem_o,
    output exe_pipe_pkg::redirect_t   redirect_o
);

import exe_isa_pkg::*;
import exe_pipe_pkg::*;

// ----------------------------------------
// redirect

logic  redir_taken;
arch_t redir_target;

assign redir_taken = (exe_i.is_branch && br_taken_i) || exe_i.is_jalr;

// branch target comes from decode, jalr target is the alu sum
always_comb begin
    redir_target = '0;
    if (redir_taken) begin
        redir_target = exe_i.is_branch ? exe_i.branch_target : alu_i;
    end
end

// next register contents
exe_mem_t  mem_d;
redirect_t redirect_d;

assign mem_d = '{
    valid:   exe_i.valid,
    pc:      exe_i.pc,
    result:  ewb_i,
    rd_we:   exe_i.rd_we,
    rd_addr: exe_i.rd_addr
};
assign redirect_d = '{taken: redir_taken, target: redir_target};

// ----------------------------------------
// exe/mem register

always_ff @(posedge clk) begin
    if (rst || ctrl_i.flush) begin
        mem_o      <= '0;
        redirect_o <= '0;
    end else if (ctrl_i.en) begin
        if (ctrl_i.bubble) begin
            // nop into mem, nothing to write back or redirect
            mem_o      <= '0;
            redirect_o <= '0;
        end else begin
            mem_o      <= mem_d;
            redirect_o <= redirect_d;
        end
    end
end

// flushed slot must not retire
a_flush_clears: assert property (
    @(posedge clk) disable iff (rst)
    ctrl_i.flush |=> !mem_o.valid && !redirect_o.taken
) else $error("valid or redirect left set after a flush");

// back-pressure keeps the item in place
a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    (!ctrl_i.flush && !ctrl_i.en) |=> $stable(mem_o) && $stable(redirect_o)
) else $error("exe/mem contents changed while held");

endmodule

// File: source/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  exe_isa_pkg::arch_t       op_a_i,
    input  exe_isa_pkg::arch_t       op_b_i,
    input  exe_isa_pkg::branch_sel_t br_sel_i,
    input  logic                     bc_uns_i,
    input  logic                     is_branch_i,
    output logic                     taken_o
);

import exe_isa_pkg::*;

// ----------------------------------------
// branch compare

logic a_eq_b;
logic a_lt_b;
assign a_eq_b = (op_a_i == op_b_i);
// bltu and bgeu reuse the same comparator
assign a_lt_b = bc_uns_i ? (op_a_i < op_b_i) : ($signed(op_a_i) < $signed(op_b_i));

// condition resolution
logic cond;
always_comb begin
    cond = 1'b0;
    case (br_sel_i)
        BR_BEQ: cond = a_eq_b;
        BR_BNE: cond = !a_eq_b;
        BR_BLT: cond = a_lt_b;
        BR_BGE: cond = a_eq_b || !a_lt_b;
        default: cond = 1'b0;
    endcase
end

// only a real branch may report taken
assign taken_o = is_branch_i && cond;

// decode sends a defined condition with every branch
a_branch_ctrl_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(is_branch_i) && (!is_branch_i || !$isunknown({br_sel_i, bc_uns_i}))
) else $error("unknown branch control on a branch instruction");

endmodule

// File: source/alu_unit.sv
`timescale 1ns/10ps
`include "exe_macros.svh"

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  exe_isa_pkg::arch_t    op_a_i,
    input  exe_isa_pkg::arch_t    op_b_i,
    input  exe_isa_pkg::arch_t    pc_i,
    input  exe_isa_pkg::alu_op_t  alu_op_i,
    input  exe_isa_pkg::ewb_sel_t ewb_sel_i,
    output exe_isa_pkg::arch_t    alu_o,
    output exe_isa_pkg::arch_t    ewb_o
);

import exe_isa_pkg::*;

// shift amount, rv32 uses the low five bits only
logic [4:0] shamt;
assign shamt = op_b_i[4:0];

// compares for slt and sltu
logic lt_s;
logic lt_u;
assign lt_s = ($signed(op_a_i) < $signed(op_b_i));
assign lt_u = (op_a_i < op_b_i);

// ----------------------------------------
// alu

always_comb begin
    case (alu_op_i)
        ALU_ADD:    alu_o = op_a_i + op_b_i;
        ALU_SUB:    alu_o = op_a_i - op_b_i;
        ALU_SLL:    alu_o = op_a_i << shamt;
        ALU_SLT:    alu_o = arch_t'(lt_s);
        ALU_SLTU:   alu_o = arch_t'(lt_u);
        ALU_XOR:    alu_o = op_a_i ^ op_b_i;
        ALU_SRL:    alu_o = op_a_i >> shamt;
        ALU_SRA:    alu_o = arch_t'($signed(op_a_i) >>> shamt);
        ALU_OR:     alu_o = op_a_i | op_b_i;
        ALU_AND:    alu_o = op_a_i & op_b_i;
        // lui style, b already holds the upper immediate
        ALU_PASS_B: alu_o = op_b_i;
        default:    alu_o = '0;
    endcase
end

// ----------------------------------------
// execute writeback mux

always_comb begin
    case (ewb_sel_i)
        EWB_ALU:     ewb_o = alu_o;
        EWB_IMM_U:   ewb_o = op_b_i;
        // link address for jal and jalr
        EWB_PC_INC4: ewb_o = pc_i + arch_t'(`EXE_PC_STEP);
        default:     ewb_o = '0;
    endcase
end

// decode only emits defined codes, even for bubbles
a_ctrl_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({alu_op_i, ewb_sel_i}) && (alu_op_i <= ALU_PASS_B) &&
    (ewb_sel_i inside {EWB_ALU, EWB_IMM_U, EWB_PC_INC4})
) else $error("unknown alu op %0d or writeback select %0d", alu_op_i, ewb_sel_i);

endmodule

// File: source/operand_resolve.sv
`timescale 1ns/10ps

module operand_resolve (
    input  logic                clk,
    input  logic                rst,
    input  exe_isa_pkg::arch_t  op_a_i,
    input  exe_isa_pkg::arch_t  op_b_i,
    input  exe_pipe_pkg::fwd_t  fwd_i,
    output exe_isa_pkg::arch_t  op_a_o,
    output exe_isa_pkg::arch_t  op_b_o
);

import exe_isa_pkg::*;
import exe_pipe_pkg::*;

// three-way bypass, same for both operands
function automatic arch_t bypass(
    input fwd_sel_t sel,
    input arch_t    reg_val,
    input fwd_t     fwd
);
    arch_t val;
    case (sel)
        FWD_MEM: val = fwd.mem_val;
        FWD_WBK: val = fwd.wbk_val;
        default: val = reg_val;
    endcase
    return val;
endfunction

// ----------------------------------------
// operand muxes

// mem is the younger producer, so it is checked by the caller first
assign op_a_o = bypass(fwd_i.sel_a, op_a_i, fwd_i);
assign op_b_o = bypass(fwd_i.sel_b, op_b_i, fwd_i);

// ----------------------------------------
// checks

// the hazard logic upstream never sends the spare code
a_fwd_sel_legal: assert property (
    @(posedge clk) disable iff (rst)
    (fwd_i.sel_a inside {FWD_NONE, FWD_MEM, FWD_WBK}) &&
    (fwd_i.sel_b inside {FWD_NONE, FWD_MEM, FWD_WBK})
) else $error("illegal forwarding select a=%0d b=%0d", fwd_i.sel_a, fwd_i.sel_b);

endmodule

// File: source/exe_pipe_pkg.sv
`include "exe_macros.svh"

package exe_pipe_pkg;

import exe_isa_pkg::*;

// ----------------------------------------
// pipeline control

// bypass source for one operand
typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WBK  = 2'd2
} fwd_sel_t;

// flush wins over en, en low holds, bubble loads a nop
typedef struct packed {
    logic flush;
    logic en;
    logic bubble;
} stage_ctrl_t;

// ----------------------------------------
// stage payloads

// decoded instruction entering execute
typedef struct packed {
    logic        valid;
    arch_t       pc;
    arch_t       op_a;
    arch_t       op_b;
    arch_t       branch_target;
    alu_op_t     alu_op;
    branch_sel_t br_sel;
    ewb_sel_t    ewb_sel;
    logic        bc_uns;
    logic        is_branch;
    logic        is_jalr;
    logic        rd_we;
    rf_addr_t    rd_addr;
} exe_in_t;

// selects and bypass values from mem and writeback
typedef struct packed {
    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    arch_t    mem_val;
    arch_t    wbk_val;
} fwd_t;

// exe/mem register contents
typedef struct packed {
    logic     valid;
    arch_t    pc;
    arch_t    result;
    logic     rd_we;
    rf_addr_t rd_addr;
} exe_mem_t;

// pc redirect toward fetch
typedef struct packed {
    logic  taken;
    arch_t target;
} redirect_t;

endpackage : exe_pipe_pkg

// File: source/exe_isa_pkg.sv
`include "exe_macros.svh"

package exe_isa_pkg;

// ----------------------------------------
// architectural words

// one data word or one pc
typedef logic [`EXE_XLEN-1:0] arch_t;

// destination register index
typedef logic [`EXE_RF_AW-1:0] rf_addr_t;

// ----------------------------------------
// operation codes

// alu operations, codes above pass_b unused
typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
} alu_op_t;

// branch conditions, same order as funct3 without the unsigned bit
typedef enum logic [1:0] {
    BR_BEQ = 2'd0,
    BR_BNE = 2'd1,
    BR_BLT = 2'd2,
    BR_BGE = 2'd3
} branch_sel_t;

// execute stage writeback source
typedef enum logic [1:0] {
    EWB_ALU     = 2'd0,
    EWB_IMM_U   = 2'd1,
    EWB_PC_INC4 = 2'd2
} ewb_sel_t;

endpackage : exe_isa_pkg

// File: source/exe_macros.svh
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// ----------------------------------------
// datapath sizes

// data word and pc width
`define EXE_XLEN 32

// register file index width, x0..x31
`define EXE_RF_AW 5

// ----------------------------------------
// sequential flow

// bytes per instruction, no compressed isa
`define EXE_PC_STEP 4

`endif
